// File: filelist.f
hw/db_pkg.sv
hw/htable_pkg.sv
hw/htable_key_dispatch.sv
hw/htable_bank.sv
hw/htable_lookup_merge.sv
hw/htable_update_ctrl.sv
hw/htable_core.sv
verif/htable_core_tb.sv

// File: hw/db_pkg.sv
/*
 * Database operation types
 * Update commands and result status codes shared by the
 * hash table RTL and its testbench
 */
package db_pkg;

    // Update command, one bit
    typedef enum logic {
        DB_CMD_INSERT = 1'b0,
        DB_CMD_DELETE = 1'b1
    } db_cmd_e;

    // Result of one update
    typedef enum logic [1:0] {
        DB_OK        = 2'd0,  // insert written or delete done
        DB_FULL      = 2'd1,  // all candidate slots hold other keys
        DB_NOT_FOUND = 2'd2   // delete of an absent key
    } db_status_e;

endpackage

// File: hw/htable_bank.sv
/*
 * Table bank
 * Key, value and valid store with a lookup read port, a probe
 * read port and one write port; clears all valid bits by an
 * address sweep after reset
 */
`timescale 1ns/1ns

module htable_bank #(
    parameter int TABLE_DEPTH = 64
)(
    input  logic                   clk,
    input  logic                   reset,
    output logic                   init_done,
    input  htable_pkg::slot_t      lookup_slot,
    input  htable_pkg::slot_t      probe_slot,
    input  logic                   lookup_valid,
    input  logic                   probe_valid,
    input  htable_pkg::bank_wr_t   wr,
    output htable_pkg::bank_rd_t   lookup_rd,
    output htable_pkg::bank_rd_t   probe_rd
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    typedef enum logic {
        SWEEP,
        READY
    } bank_state_e;

    bank_state_e       state;
    logic [IDX_W-1:0]  sweep_addr;

    // Storage
    htable_pkg::key_t    key_mem [TABLE_DEPTH];
    htable_pkg::value_t  val_mem [TABLE_DEPTH];
    logic                vld_mem [TABLE_DEPTH];

    // Read port registers
    logic                lookup_rd_valid;
    logic                probe_rd_valid;
    logic                lookup_slot_valid;
    logic                probe_slot_valid;
    htable_pkg::key_t    lookup_key;
    htable_pkg::key_t    probe_key;
    htable_pkg::value_t  lookup_value;
    htable_pkg::value_t  probe_value;

    // ------------------------------
    // Init sweep
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= SWEEP;
            sweep_addr <= '0;
        end else if (state == SWEEP) begin
            sweep_addr <= sweep_addr + 1'b1;
            // Last address cleared this cycle
            if (sweep_addr == IDX_W'(TABLE_DEPTH - 1)) begin
                state <= READY;
            end
        end
    end

    assign init_done = (state == READY);

    // Write port, sweep has priority
    always_ff @(posedge clk) begin
        if (state == SWEEP) begin
            vld_mem[sweep_addr] <= 1'b0;
        end else if (wr.strobe) begin
            vld_mem[wr.slot[IDX_W-1:0]] <= wr.slot_valid;
            key_mem[wr.slot[IDX_W-1:0]] <= wr.key;
            val_mem[wr.slot[IDX_W-1:0]] <= wr.value;
        end
    end

    // ------------------------------
    // Read ports
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_rd_valid <= 1'b0;
            probe_rd_valid  <= 1'b0;
        end else begin
            lookup_rd_valid <= lookup_valid;
            probe_rd_valid  <= probe_valid;
        end
    end

    // Old data on a same-cycle write
    always_ff @(posedge clk) begin
        lookup_slot_valid <= vld_mem[lookup_slot[IDX_W-1:0]];
        lookup_key        <= key_mem[lookup_slot[IDX_W-1:0]];
        lookup_value      <= val_mem[lookup_slot[IDX_W-1:0]];
        probe_slot_valid  <= vld_mem[probe_slot[IDX_W-1:0]];
        probe_key         <= key_mem[probe_slot[IDX_W-1:0]];
        probe_value       <= val_mem[probe_slot[IDX_W-1:0]];
    end

    assign lookup_rd = '{valid: lookup_rd_valid, slot_valid: lookup_slot_valid,
                         key: lookup_key, value: lookup_value};
    assign probe_rd  = '{valid: probe_rd_valid, slot_valid: probe_slot_valid,
                         key: probe_key, value: probe_value};

endmodule

// File: hw/htable_core.sv
/*
 * Hash table lookup engine
 * Key dispatch, parallel table banks, lookup merger and
 * update controller; 3-cycle lookups, 4-cycle updates
 */
`timescale 1ns/1ns

module htable_core #(
    parameter int NUM_TABLES  = 3,
    parameter int TABLE_DEPTH = 64
)(
    input  logic                      clk,
    input  logic                      reset,
    input  htable_pkg::lookup_req_t   lookup_req,
    output htable_pkg::lookup_resp_t  lookup_resp,
    input  htable_pkg::upd_req_t      upd_req,
    output htable_pkg::upd_resp_t     upd_resp,
    output logic                      upd_busy,
    output logic                      init_done
);

    // ------------------------------
    // Signals
    // ------------------------------
    htable_pkg::lookup_req_t  lookup_gated;
    htable_pkg::slot_t        lookup_slot [NUM_TABLES];
    htable_pkg::slot_t        probe_slot  [NUM_TABLES];
    logic                     lookup_valid;
    logic                     probe_valid;
    logic                     probe_strobe;
    htable_pkg::key_t         probe_key;
    htable_pkg::bank_rd_t     lookup_rd   [NUM_TABLES];
    htable_pkg::bank_rd_t     probe_rd    [NUM_TABLES];
    htable_pkg::bank_wr_t     bank_wr     [NUM_TABLES];
    logic                     bank_init_done [NUM_TABLES];

    // Key pipe, lines up with the bank reads
    htable_pkg::key_t         key_hash_q;
    htable_pkg::key_t         key_read_q;

    // Lookups before init_done are dropped
    assign lookup_gated = '{strobe: lookup_req.strobe && init_done, key: lookup_req.key};

    always_ff @(posedge clk) begin
        key_hash_q <= lookup_req.key;
        key_read_q <= key_hash_q;
    end

    // All banks swept
    always_comb begin
        init_done = 1'b1;
        for (int t = 0; t < NUM_TABLES; t++) begin
            init_done = init_done & bank_init_done[t];
        end
    end

    // ------------------------------
    // Blocks
    // ------------------------------
    htable_key_dispatch #(
        .NUM_TABLES   ( NUM_TABLES ),
        .TABLE_DEPTH  ( TABLE_DEPTH )
    ) u_dispatch (
        .clk          ( clk ),
        .reset        ( reset ),
        .lookup_req   ( lookup_gated ),
        .probe_strobe ( probe_strobe ),
        .probe_key    ( probe_key ),
        .lookup_slot  ( lookup_slot ),
        .probe_slot   ( probe_slot ),
        .lookup_valid ( lookup_valid ),
        .probe_valid  ( probe_valid )
    );

    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_bank
        htable_bank #(
            .TABLE_DEPTH  ( TABLE_DEPTH )
        ) u_bank (
            .clk          ( clk ),
            .reset        ( reset ),
            .init_done    ( bank_init_done[t] ),
            .lookup_slot  ( lookup_slot[t] ),
            .probe_slot   ( probe_slot[t] ),
            .lookup_valid ( lookup_valid ),
            .probe_valid  ( probe_valid ),
            .wr           ( bank_wr[t] ),
            .lookup_rd    ( lookup_rd[t] ),
            .probe_rd     ( probe_rd[t] )
        );
    end

    htable_lookup_merge #(
        .NUM_TABLES   ( NUM_TABLES )
    ) u_merge (
        .clk          ( clk ),
        .reset        ( reset ),
        .lookup_key   ( key_read_q ),
        .bank_rd      ( lookup_rd ),
        .lookup_resp  ( lookup_resp )
    );

    htable_update_ctrl #(
        .NUM_TABLES   ( NUM_TABLES )
    ) u_update (
        .clk          ( clk ),
        .reset        ( reset ),
        .init_done    ( init_done ),
        .upd_req      ( upd_req ),
        .probe_strobe ( probe_strobe ),
        .probe_key    ( probe_key ),
        .probe_slot   ( probe_slot ),
        .probe_rd     ( probe_rd ),
        .bank_wr      ( bank_wr ),
        .upd_resp     ( upd_resp ),
        .upd_busy     ( upd_busy )
    );

endmodule

// File: hw/htable_key_dispatch.sv
/*
 * Key dispatch
 * Registers the lookup and probe keys and hashes each one
 * into a slot index for every table bank
 */
`timescale 1ns/1ns

module htable_key_dispatch #(
    parameter int NUM_TABLES  = 3,
    parameter int TABLE_DEPTH = 64
)(
    input  logic                     clk,
    input  logic                     reset,
    input  htable_pkg::lookup_req_t  lookup_req,
    input  logic                     probe_strobe,
    input  htable_pkg::key_t         probe_key,
    output htable_pkg::slot_t        lookup_slot [NUM_TABLES],
    output htable_pkg::slot_t        probe_slot  [NUM_TABLES],
    output logic                     lookup_valid,
    output logic                     probe_valid
);

    // Keeps the index bits of the table depth
    localparam htable_pkg::slot_t SLOT_MASK = htable_pkg::slot_t'(TABLE_DEPTH - 1);

    // Byte fold shared by every table
    logic [7:0] lookup_fold;
    logic [7:0] probe_fold;

    assign lookup_fold = lookup_req.key[15:8] ^ lookup_req.key[7:0];
    assign probe_fold  = probe_key[15:8] ^ probe_key[7:0];

    // Strobes, one cycle behind the keys
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid <= 1'b0;
            probe_valid  <= 1'b0;
        end else begin
            lookup_valid <= lookup_req.strobe;
            probe_valid  <= probe_strobe;
        end
    end

    // ------------------------------
    // Per-table hash
    // ------------------------------
    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_hash
        // Table salt is t * 37, modulo a byte
        localparam logic [7:0] SALT = 8'((t * 37) % 256);

        always_ff @(posedge clk) begin
            lookup_slot[t] <= (lookup_fold ^ SALT) & SLOT_MASK;
            // Probe slot holds until the next probe
            if (probe_strobe) begin
                probe_slot[t] <= (probe_fold ^ SALT) & SLOT_MASK;
            end
        end
    end

endmodule

// File: hw/htable_lookup_merge.sv
/*
 * Lookup merger
 * Matches the key against every bank read and returns one
 * registered hit and value, lowest bank first
 */
`timescale 1ns/1ns

module htable_lookup_merge #(
    parameter int NUM_TABLES = 3
)(
    input  logic                      clk,
    input  logic                      reset,
    input  htable_pkg::key_t          lookup_key,
    input  htable_pkg::bank_rd_t      bank_rd [NUM_TABLES],
    output htable_pkg::lookup_resp_t  lookup_resp
);

    logic                rd_valid;
    logic                any_hit;
    htable_pkg::value_t  hit_value;

    logic                resp_valid;
    logic                resp_hit;
    htable_pkg::value_t  resp_value;

    // Walk down so the lowest hitting bank wins
    always_comb begin
        rd_valid  = 1'b0;
        any_hit   = 1'b0;
        hit_value = '0;
        for (int i = NUM_TABLES - 1; i >= 0; i--) begin
            rd_valid = rd_valid | bank_rd[i].valid;
            if (bank_rd[i].slot_valid && (bank_rd[i].key == lookup_key)) begin
                any_hit   = 1'b1;
                hit_value = bank_rd[i].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        resp_hit   <= any_hit;
        resp_value <= hit_value;
    end

    assign lookup_resp = '{valid: resp_valid, hit: resp_hit, value: resp_value};

endmodule

// File: hw/htable_pkg.sv
/*
 * Hash table types
 * Key, value and slot vectors plus the packed request, probe
 * and response structs passed between the lookup engine blocks
 */
package htable_pkg;

    typedef logic [15:0] key_t;
    typedef logic [15:0] value_t;
    // Wide enough for 256 slots, banks use the low bits only
    typedef logic [7:0]  slot_t;

    typedef struct packed {
        logic   strobe;
        key_t   key;
    } lookup_req_t;

    typedef struct packed {
        logic   valid;
        logic   hit;
        value_t value;
    } lookup_resp_t;

    typedef struct packed {
        logic              strobe;
        db_pkg::db_cmd_e   cmd;
        key_t              key;
        value_t            value;
    } upd_req_t;

    typedef struct packed {
        logic              done;
        db_pkg::db_status_e status;
    } upd_resp_t;

    // Bank read port result
    typedef struct packed {
        logic   valid;
        logic   slot_valid;
        key_t   key;
        value_t value;
    } bank_rd_t;

    // Bank write port command
    typedef struct packed {
        logic   strobe;
        slot_t  slot;
        logic   slot_valid;
        key_t   key;
        value_t value;
    } bank_wr_t;

endpackage

// File: hw/htable_update_ctrl.sv
/*
 * Update controller
 * Runs one insert or delete at a time: probe all banks, pick
 * the target slot, write it and report the status
 */
`timescale 1ns/1ns

module htable_update_ctrl #(
    parameter int NUM_TABLES = 3
)(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    init_done,
    input  htable_pkg::upd_req_t    upd_req,
    output logic                    probe_strobe,
    output htable_pkg::key_t        probe_key,
    input  htable_pkg::slot_t       probe_slot [NUM_TABLES],
    input  htable_pkg::bank_rd_t    probe_rd   [NUM_TABLES],
    output htable_pkg::bank_wr_t    bank_wr    [NUM_TABLES],
    output htable_pkg::upd_resp_t   upd_resp,
    output logic                    upd_busy
);

    localparam int IDX_W = (NUM_TABLES > 1) ? $clog2(NUM_TABLES) : 1;

    typedef enum logic [2:0] {
        IDLE,
        HASH,
        PROBE,
        COMMIT,
        DONE
    } upd_state_e;

    upd_state_e  state;
    upd_state_e  state_nxt;
    logic        accept;

    // Latched request
    db_pkg::db_cmd_e     req_cmd;
    htable_pkg::key_t    req_key;
    htable_pkg::value_t  req_value;

    // Commit decision
    logic                found;
    logic                empty;
    logic [IDX_W-1:0]    found_bank;
    logic [IDX_W-1:0]    empty_bank;
    logic [IDX_W-1:0]    tgt_bank;
    logic                do_write;
    db_pkg::db_status_e  commit_status;
    db_pkg::db_status_e  status_q;

    // ------------------------------
    // FSM
    // ------------------------------
    assign upd_busy = (state == HASH) || (state == PROBE) || (state == COMMIT);
    // Also taken in DONE, busy is already low there
    assign accept   = upd_req.strobe && init_done && !upd_busy;

    always_comb begin
        case (state)
            IDLE, DONE: state_nxt = accept ? HASH : IDLE;
            HASH:       state_nxt = PROBE;
            PROBE:      state_nxt = COMMIT;
            COMMIT:     state_nxt = DONE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_cmd   <= upd_req.cmd;
            req_key   <= upd_req.key;
            req_value <= upd_req.value;
        end
        if (state == COMMIT) begin
            status_q <= commit_status;
        end
    end

    // Key goes to the dispatch during HASH
    assign probe_strobe = (state == HASH);
    assign probe_key    = req_key;

    // ------------------------------
    // Target selection
    // ------------------------------
    always_comb begin
        found      = 1'b0;
        empty      = 1'b0;
        found_bank = '0;
        empty_bank = '0;
        // Downward walk leaves the lowest bank selected
        for (int i = NUM_TABLES - 1; i >= 0; i--) begin
            if (probe_rd[i].valid && probe_rd[i].slot_valid &&
                (probe_rd[i].key == req_key)) begin
                found      = 1'b1;
                found_bank = IDX_W'(i);
            end
            if (probe_rd[i].valid && !probe_rd[i].slot_valid) begin
                empty      = 1'b1;
                empty_bank = IDX_W'(i);
            end
        end

        tgt_bank = found_bank;
        do_write = found;
        if (found) begin
            commit_status = db_pkg::DB_OK;
        end else if (req_cmd == db_pkg::DB_CMD_DELETE) begin
            commit_status = db_pkg::DB_NOT_FOUND;
        end else if (empty) begin
            // New key into the first free bank
            tgt_bank      = empty_bank;
            do_write      = 1'b1;
            commit_status = db_pkg::DB_OK;
        end else begin
            commit_status = db_pkg::DB_FULL;
        end
    end

    // One write strobe at most, only in COMMIT
    for (genvar i = 0; i < NUM_TABLES; i++) begin : g_wr
        assign bank_wr[i] = '{
            strobe:     (state == COMMIT) && do_write && (tgt_bank == IDX_W'(i)),
            slot:       probe_slot[i],
            slot_valid: (req_cmd == db_pkg::DB_CMD_INSERT),
            key:        req_key,
            value:      req_value
        };
    end

    assign upd_resp = '{done: (state == DONE), status: status_q};

endmodule

// File: verif/htable_core_tb.sv
/*
 * Hash table engine testbench
 * Reference model of the banks and hash, update and lookup
 * stimulus, pipelined response checks with latency
 */
`timescale 1ns/1ns

module htable_core_tb;

    localparam int NUM_TABLES    = 3;
    localparam int TABLE_DEPTH   = 64;
    localparam int INIT_TIMEOUT  = 4 * TABLE_DEPTH;
    localparam int UPD_TIMEOUT   = 20;
    localparam int DRAIN_TIMEOUT = 20;

    logic                      clk = 1'b0;
    logic                      reset;
    htable_pkg::lookup_req_t   lookup_req;
    htable_pkg::lookup_resp_t  lookup_resp;
    htable_pkg::upd_req_t      upd_req;
    htable_pkg::upd_resp_t     upd_resp;
    logic                      upd_busy;
    logic                      init_done;

    // Reference tables
    htable_pkg::key_t    ref_key [NUM_TABLES][TABLE_DEPTH];
    htable_pkg::value_t  ref_val [NUM_TABLES][TABLE_DEPTH];
    logic                ref_vld [NUM_TABLES][TABLE_DEPTH];

    // Outstanding lookups and their issue cycles
    htable_pkg::lookup_resp_t  exp_q [$];
    int                        cyc_q [$];
    htable_pkg::lookup_resp_t  exp_resp;
    int                        exp_cycle;
    int                        cycle_cnt = 0;
    string                     cur_test = "reset";
    htable_pkg::key_t          used_keys [$];

    htable_core #(
        .NUM_TABLES   ( NUM_TABLES ),
        .TABLE_DEPTH  ( TABLE_DEPTH )
    ) uut (
        .clk          ( clk ),
        .reset        ( reset ),
        .lookup_req   ( lookup_req ),
        .lookup_resp  ( lookup_resp ),
        .upd_req      ( upd_req ),
        .upd_resp     ( upd_resp ),
        .upd_busy     ( upd_busy ),
        .init_done    ( init_done )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    // Slot of a key in table t
    function automatic int hash_slot(htable_pkg::key_t key, int t);
        logic [7:0] mixed;
        mixed = key[15:8] ^ key[7:0] ^ 8'(t * 37);
        return mixed % TABLE_DEPTH;
    endfunction

    function automatic htable_pkg::lookup_resp_t ref_lookup(htable_pkg::key_t key);
        htable_pkg::lookup_resp_t resp;
        int t;
        int s;
        resp = '{valid: 1'b1, hit: 1'b0, value: '0};
        // Lowest bank wins
        for (t = NUM_TABLES - 1; t >= 0; t--) begin
            s = hash_slot(key, t);
            if (ref_vld[t][s] && ref_key[t][s] == key) begin
                resp.hit   = 1'b1;
                resp.value = ref_val[t][s];
            end
        end
        return resp;
    endfunction

    function automatic db_pkg::db_status_e ref_update(db_pkg::db_cmd_e cmd,
                                                      htable_pkg::key_t key,
                                                      htable_pkg::value_t value);
        int found_t;
        int empty_t;
        int t;
        int s;
        found_t = -1;
        empty_t = -1;
        for (t = NUM_TABLES - 1; t >= 0; t--) begin
            s = hash_slot(key, t);
            if (ref_vld[t][s] && ref_key[t][s] == key) found_t = t;
            if (!ref_vld[t][s]) empty_t = t;
        end
        if (found_t >= 0) begin
            s = hash_slot(key, found_t);
            if (cmd == db_pkg::DB_CMD_DELETE) ref_vld[found_t][s] = 1'b0;
            else ref_val[found_t][s] = value;
            return db_pkg::DB_OK;
        end
        if (cmd == db_pkg::DB_CMD_DELETE) return db_pkg::DB_NOT_FOUND;
        // All candidates taken and no eviction
        if (empty_t < 0) return db_pkg::DB_FULL;
        s = hash_slot(key, empty_t);
        ref_vld[empty_t][s] = 1'b1;
        ref_key[empty_t][s] = key;
        ref_val[empty_t][s] = value;
        return db_pkg::DB_OK;
    endfunction

    // ------------------------------
    // Checks and stimulus helpers
    // ------------------------------
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected %0h actual %0h", cur_test, what, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    // Drives one strobe and queues its expected response
    task automatic issue_lookup(htable_pkg::key_t key);
        lookup_req = '{strobe: 1'b1, key: key};
        exp_q.push_back(ref_lookup(key));
        cyc_q.push_back(cycle_cnt);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_TIMEOUT) abort_run("timeout waiting for lookup responses");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic lookup_and_drain(htable_pkg::key_t key);
        issue_lookup(key);
        @(negedge clk);
        lookup_req.strobe = 1'b0;
        wait_drain();
    endtask

    task automatic run_update(db_pkg::db_cmd_e cmd, htable_pkg::key_t key,
                              htable_pkg::value_t value);
        db_pkg::db_status_e exp_status;
        int start;
        int waited;
        exp_status = ref_update(cmd, key, value);
        start = cycle_cnt;
        upd_req = '{strobe: 1'b1, cmd: cmd, key: key, value: value};
        @(negedge clk);
        upd_req.strobe = 1'b0;
        check_value("upd_busy after strobe", 1, upd_busy);
        waited = 0;
        while (!upd_resp.done) begin
            if (waited >= UPD_TIMEOUT) abort_run("timeout waiting for the update done pulse");
            @(negedge clk);
            waited++;
        end
        check_value("update latency", 4, cycle_cnt - start);
        check_value("update status", exp_status, upd_resp.status);
        check_value("upd_busy at done", 0, upd_busy);
    endtask

    // Oldest outstanding lookup checked on every response
    always @(negedge clk) begin
        if (!reset && lookup_resp.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("lookup response arrived with no lookup outstanding");
            end else begin
                exp_resp  = exp_q.pop_front();
                exp_cycle = cyc_q.pop_front();
                check_value("lookup latency", 3, cycle_cnt - exp_cycle);
                check_value("lookup hit", exp_resp.hit, lookup_resp.hit);
                if (exp_resp.hit) check_value("lookup value", exp_resp.value, lookup_resp.value);
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int seed_val;
        int waited;
        int i;
        int t;
        int f;
        int fold;
        logic free;
        htable_pkg::key_t k;
        htable_pkg::key_t coll [4];
        htable_pkg::lookup_resp_t held;

        seed_val   = $urandom(32'h131a_cfb7);
        reset      = 1'b1;
        lookup_req = '0;
        upd_req    = '0;
        for (t = 0; t < NUM_TABLES; t++) begin
            for (i = 0; i < TABLE_DEPTH; i++) ref_vld[t][i] = 1'b0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_value("init_done after reset", 0, init_done);
        check_value("upd_busy after reset", 0, upd_busy);
        check_value("lookup valid after reset", 0, lookup_resp.valid);
        check_value("update done after reset", 0, upd_resp.done);

        // Every lookup misses once the sweep is done
        cur_test = "init";
        waited = 0;
        while (!init_done) begin
            if (waited >= INIT_TIMEOUT) abort_run("timeout waiting for init_done");
            @(negedge clk);
            waited++;
        end
        for (i = 0; i < 4; i++) lookup_and_drain(htable_pkg::key_t'($urandom));

        cur_test = "insert";
        for (i = 0; i < 40; i++) begin
            k = htable_pkg::key_t'($urandom);
            used_keys.push_back(k);
            run_update(db_pkg::DB_CMD_INSERT, k, htable_pkg::value_t'($urandom));
        end
        foreach (used_keys[j]) lookup_and_drain(used_keys[j]);

        // New value on a key the model holds
        cur_test = "overwrite";
        k = used_keys[0];
        for (i = used_keys.size() - 1; i >= 0; i--) begin
            held = ref_lookup(used_keys[i]);
            if (held.hit) k = used_keys[i];
        end
        run_update(db_pkg::DB_CMD_INSERT, k, 16'hbeef);
        lookup_and_drain(k);

        // Same byte fold gives the same slot in every table
        cur_test = "collision";
        fold = -1;
        for (f = 0; f < 256 && fold < 0; f++) begin
            free = 1'b1;
            for (t = 0; t < NUM_TABLES; t++) begin
                if (ref_vld[t][hash_slot({8'h00, 8'(f)}, t)]) free = 1'b0;
            end
            if (free) fold = f;
        end
        if (fold < 0) abort_run("no free slot group left for the collision test");
        for (i = 0; i < 4; i++) begin
            coll[i] = {8'(i + 1), 8'(i + 1) ^ 8'(fold)};
            run_update(db_pkg::DB_CMD_INSERT, coll[i], 16'h1000 + 16'(i));
        end
        for (i = 0; i < 4; i++) lookup_and_drain(coll[i]);

        cur_test = "delete";
        run_update(db_pkg::DB_CMD_DELETE, coll[1], '0);
        lookup_and_drain(coll[1]);
        run_update(db_pkg::DB_CMD_DELETE, coll[1], '0);
        lookup_and_drain(coll[0]);
        lookup_and_drain(coll[2]);

        // One strobe per cycle with hits and misses mixed
        cur_test = "back_to_back";
        for (i = 0; i < 32; i++) begin
            if (i % 3 == 2) issue_lookup(htable_pkg::key_t'($urandom));
            else issue_lookup(used_keys[$urandom % used_keys.size()]);
            @(negedge clk);
        end
        lookup_req.strobe = 1'b0;
        wait_drain();

        $display("RESULT: PASS");
        $finish;
    end

endmodule
